/* files.f */
swarm_cfg_pkg.sv
swarm_types_pkg.sv
tile_hash.sv
task_sender.sv
task_noc.sv
tile_task_queue.sv
swarm_tsb_sys.sv
tb_swarm_tsb_sys.sv

/* swarm_cfg_pkg.sv */
package swarm_cfg_pkg;

   // array sizing
   localparam int N_TILES      = 4;
   localparam int LOG_TSB_SIZE = 3;
   localparam int TSB_SIZE     = 2 ** LOG_TSB_SIZE;
   localparam int TQ_DEPTH     = 4;

   // wishbone word addresses
   localparam logic [1:0] TSB_REG_N_TILES = 2'd0;
   localparam logic [1:0] TSB_REG_HASH    = 2'd1;
   localparam logic [1:0] TSB_REG_VALID   = 2'd2;
   localparam logic [1:0] TSB_REG_COUNT   = 2'd3;

   // one key per hashed locale bit
   localparam logic [0:15][31:0] hash_keys = {
      32'h7a3e91c5, 32'h1f06d2b8, 32'hc4597e03, 32'h38b2a6f1,
      32'h9e0d4c57, 32'h52f8b31a, 32'hd16a0e9c, 32'h0b7c55e2,
      32'h6e93f4a0, 32'ha2c81d37, 32'h4d05b96e, 32'hf7e2603b,
      32'h2958ca14, 32'hb03f7d89, 32'h85a1e2c6, 32'h13d94f7d
   };

endpackage

/* swarm_tsb_sys.sv */
`timescale 1ns/1ps

module swarm_tsb_sys import swarm_cfg_pkg::*, swarm_types_pkg::*; (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 s_valid,
   output logic                 s_ready,
   input  task_t                s_task,
   input  logic                 s_tied,
   input  cq_slot_t             s_cq_slot,
   input  child_id_t            s_child_id,
   input  logic                 retry_valid,
   output logic                 retry_ready,
   input  tsb_entry_id_t        retry_id,
   input  logic                 retry_abort,
   input  logic                 retry_tied,
   output logic                 m_resp_valid,
   input  logic                 m_resp_ready,
   output logic                 m_resp_ack,
   output tsb_entry_id_t        m_resp_id,
   output epoch_t               m_resp_epoch,
   output tq_slot_t             m_resp_slot,
   output tile_id_t             m_resp_tile,
   output cq_slot_t             m_resp_cq_slot,
   output child_id_t            m_resp_child_id,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  logic [1:0]           wb_adr,
   input  logic [31:0]          wb_dat_w,
   output logic [31:0]          wb_dat_r,
   output logic                 wb_ack,
   output ts_t                  lvt,
   output logic                 empty,
   output logic                 almost_full,
   output logic [N_TILES-1:0]   deq_valid,
   input  logic [N_TILES-1:0]   deq_ready,
   output task_t [N_TILES-1:0]  deq_task
);

   logic                        enq_valid;
   logic                        enq_ready;
   task_t                       enq_task;
   tile_id_t                    enq_dest;
   tsb_entry_id_t               enq_id;
   logic                        resp_valid;
   logic                        resp_ready;
   logic                        resp_ack;
   tsb_entry_id_t               resp_id;
   epoch_t                      resp_epoch;
   tq_slot_t                    resp_slot;
   logic [N_TILES-1:0]          tq_enq_valid;
   logic [N_TILES-1:0]          tq_enq_ready;
   task_t                       tq_enq_task;
   tsb_entry_id_t               tq_enq_id;
   logic [N_TILES-1:0]          tq_resp_valid;
   logic [N_TILES-1:0]          tq_resp_ready;
   logic [N_TILES-1:0]          tq_resp_ack;
   tsb_entry_id_t [N_TILES-1:0] tq_resp_id;
   epoch_t [N_TILES-1:0]        tq_resp_epoch;
   tq_slot_t [N_TILES-1:0]      tq_resp_slot;

   // tied flag on the enqueue stays at the sender, tiles keep no copy
   task_sender i_sender (
      .clk, .rstn,
      .s_valid, .s_ready, .s_task, .s_tied, .s_cq_slot, .s_child_id,
      .retry_valid, .retry_ready, .retry_id, .retry_abort, .retry_tied,
      .enq_valid, .enq_ready, .enq_task, .enq_tied (), .enq_dest, .enq_id,
      .resp_valid, .resp_ready, .resp_ack, .resp_id, .resp_epoch, .resp_slot,
      .m_resp_valid, .m_resp_ready, .m_resp_ack, .m_resp_id, .m_resp_epoch,
      .m_resp_slot, .m_resp_tile, .m_resp_cq_slot, .m_resp_child_id,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
      .lvt, .empty, .almost_full
   );

   task_noc i_noc (
      .clk, .rstn,
      .enq_valid, .enq_ready, .enq_task, .enq_dest, .enq_id,
      .resp_valid, .resp_ready, .resp_ack, .resp_id, .resp_epoch, .resp_slot,
      .tq_enq_valid, .tq_enq_ready, .tq_enq_task, .tq_enq_id,
      .tq_resp_valid, .tq_resp_ready, .tq_resp_ack, .tq_resp_id,
      .tq_resp_epoch, .tq_resp_slot
   );

   for (genvar t = 0; t < N_TILES; t++) begin : gen_tile
      tile_task_queue i_tq (
         .clk        (clk),
         .rstn       (rstn),
         .enq_valid  (tq_enq_valid[t]),
         .enq_ready  (tq_enq_ready[t]),
         .enq_task   (tq_enq_task),
         .enq_id     (tq_enq_id),
         .resp_valid (tq_resp_valid[t]),
         .resp_ready (tq_resp_ready[t]),
         .resp_ack   (tq_resp_ack[t]),
         .resp_id    (tq_resp_id[t]),
         .resp_epoch (tq_resp_epoch[t]),
         .resp_slot  (tq_resp_slot[t]),
         .deq_valid  (deq_valid[t]),
         .deq_ready  (deq_ready[t]),
         .deq_task   (deq_task[t])
      );
   end

endmodule

/* swarm_types_pkg.sv */
package swarm_types_pkg;

   // all ones means no timestamp
   typedef logic [15:0] ts_t;

   typedef logic [31:0] locale_t;

   typedef struct packed {
      ts_t         ts;
      locale_t     locale;
      logic [15:0] payload;
   } task_t;

   typedef logic [1:0] tile_id_t;

   typedef logic [2:0] tsb_entry_id_t;

   // bumped each time a tile queue slot is dequeued
   typedef logic [3:0] epoch_t;

   typedef logic [1:0] tq_slot_t;

   typedef logic [3:0] cq_slot_t;

   typedef logic [1:0] child_id_t;

endpackage

/* task_noc.sv */
`timescale 1ns/1ps

module task_noc import swarm_cfg_pkg::*, swarm_types_pkg::*; (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          enq_valid,
   output logic                          enq_ready,
   input  task_t                         enq_task,
   input  tile_id_t                      enq_dest,
   input  tsb_entry_id_t                 enq_id,
   output logic                          resp_valid,
   input  logic                          resp_ready,
   output logic                          resp_ack,
   output tsb_entry_id_t                 resp_id,
   output epoch_t                        resp_epoch,
   output tq_slot_t                      resp_slot,
   output logic [N_TILES-1:0]            tq_enq_valid,
   input  logic [N_TILES-1:0]            tq_enq_ready,
   output task_t                         tq_enq_task,
   output tsb_entry_id_t                 tq_enq_id,
   input  logic [N_TILES-1:0]            tq_resp_valid,
   output logic [N_TILES-1:0]            tq_resp_ready,
   input  logic [N_TILES-1:0]            tq_resp_ack,
   input  tsb_entry_id_t [N_TILES-1:0]   tq_resp_id,
   input  epoch_t [N_TILES-1:0]          tq_resp_epoch,
   input  tq_slot_t [N_TILES-1:0]        tq_resp_slot
);

   tile_id_t rr_ptr;
   tile_id_t grant;
   logic     found;

   // enqueue goes only to the addressed tile
   assign tq_enq_valid = enq_valid ? (N_TILES'(1) << enq_dest) : '0;
   assign enq_ready    = tq_enq_ready[enq_dest];
   assign tq_enq_task  = enq_task;
   assign tq_enq_id    = enq_id;

   // first pending tile at or after the pointer
   always_comb begin
      tile_id_t idx;
      found = 1'b0;
      grant = rr_ptr;
      for (int k = 0; k < N_TILES; k++) begin
         idx = rr_ptr + tile_id_t'(k);
         if (!found && tq_resp_valid[idx]) begin
            found = 1'b1;
            grant = idx;
         end
      end
   end

   assign resp_valid    = found;
   assign resp_ack      = tq_resp_ack[grant];
   assign resp_id       = tq_resp_id[grant];
   assign resp_epoch    = tq_resp_epoch[grant];
   assign resp_slot     = tq_resp_slot[grant];
   assign tq_resp_ready = (found && resp_ready) ? (N_TILES'(1) << grant) : '0;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rr_ptr <= '0;
      end else if (found && resp_ready) begin
         rr_ptr <= grant + 1'b1;
      end
   end

endmodule

/* task_sender.sv */
`timescale 1ns/1ps

module task_sender import swarm_cfg_pkg::*, swarm_types_pkg::*; (
   input  logic          clk,
   input  logic          rstn,
   input  logic          s_valid,
   output logic          s_ready,
   input  task_t         s_task,
   input  logic          s_tied,
   input  cq_slot_t      s_cq_slot,
   input  child_id_t     s_child_id,
   input  logic          retry_valid,
   output logic          retry_ready,
   input  tsb_entry_id_t retry_id,
   input  logic          retry_abort,
   input  logic          retry_tied,
   output logic          enq_valid,
   input  logic          enq_ready,
   output task_t         enq_task,
   output logic          enq_tied,
   output tile_id_t      enq_dest,
   output tsb_entry_id_t enq_id,
   input  logic          resp_valid,
   output logic          resp_ready,
   input  logic          resp_ack,
   input  tsb_entry_id_t resp_id,
   input  epoch_t        resp_epoch,
   input  tq_slot_t      resp_slot,
   output logic          m_resp_valid,
   input  logic          m_resp_ready,
   output logic          m_resp_ack,
   output tsb_entry_id_t m_resp_id,
   output epoch_t        m_resp_epoch,
   output tq_slot_t      m_resp_slot,
   output tile_id_t      m_resp_tile,
   output cq_slot_t      m_resp_cq_slot,
   output child_id_t     m_resp_child_id,
   input  logic          wb_cyc,
   input  logic          wb_stb,
   input  logic          wb_we,
   input  logic [1:0]    wb_adr,
   input  logic [31:0]   wb_dat_w,
   output logic [31:0]   wb_dat_r,
   output logic          wb_ack,
   output ts_t           lvt,
   output logic          empty,
   output logic          almost_full
);

   logic [TSB_SIZE-1:0]   entry_valid;
   task_t                 entry_task     [TSB_SIZE];
   tile_id_t              entry_tile     [TSB_SIZE];
   logic                  entry_tied     [TSB_SIZE];
   cq_slot_t              entry_cq_slot  [TSB_SIZE];
   child_id_t             entry_child_id [TSB_SIZE];
   logic [TSB_SIZE-1:0]   set_mask;
   logic [TSB_SIZE-1:0]   clr_mask;
   logic [LOG_TSB_SIZE:0] count;
   logic [2:0]            n_tiles;
   logic                  use_hash;
   tile_id_t              hash_dest;
   tsb_entry_id_t         free_id;
   tsb_entry_id_t         scan_id;
   ts_t                   scan_min;
   logic                  enq_free;
   logic                  s_fire;
   logic                  retry_fire;
   logic                  reissue;
   logic                  abort_fire;
   logic                  resp_fire;
   logic                  ack_fire;
   logic                  fwd_resp;
   logic                  wb_req;

   tile_hash i_hash (
      .locale   (s_task.locale),
      .use_hash (use_hash),
      .n_tiles  (n_tiles),
      .dest     (hash_dest)
   );

   // lowest free entry
   always_comb begin
      free_id = '0;
      for (int i = TSB_SIZE - 1; i >= 0; i--) begin
         if (!entry_valid[i]) begin
            free_id = tsb_entry_id_t'(i);
         end
      end
   end

   assign enq_free    = !enq_valid || enq_ready;
   assign s_ready     = enq_free && !(&entry_valid);
   assign s_fire      = s_valid && s_ready;
   // new tasks go ahead of retries
   assign retry_ready = enq_free && !s_fire;
   assign retry_fire  = retry_valid && retry_ready;
   assign reissue     = retry_fire && !retry_abort;
   assign abort_fire  = retry_fire && retry_abort;
   // a stalled child manager holds off every tile
   assign resp_ready  = !m_resp_valid;
   assign resp_fire   = resp_valid && resp_ready;
   assign ack_fire    = resp_fire && resp_ack;
   assign fwd_resp    = resp_fire && entry_tied[resp_id];

   assign set_mask = s_fire ? (TSB_SIZE'(1) << free_id) : '0;
   assign clr_mask = (abort_fire ? (TSB_SIZE'(1) << retry_id) : '0)
                   | (ack_fire ? (TSB_SIZE'(1) << resp_id) : '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         entry_valid <= '0;
         count       <= '0;
         enq_valid   <= 1'b0;
      end else begin
         entry_valid <= (entry_valid & ~clr_mask) | set_mask;
         count       <= count + (LOG_TSB_SIZE + 1)'(s_fire)
                              - (LOG_TSB_SIZE + 1)'(ack_fire)
                              - (LOG_TSB_SIZE + 1)'(abort_fire);
         if (s_fire || reissue) begin
            enq_valid <= 1'b1;
         end else if (enq_ready) begin
            enq_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (s_fire) begin
         enq_task                <= s_task;
         enq_tied                <= s_tied;
         enq_dest                <= hash_dest;
         enq_id                  <= free_id;
         entry_task[free_id]     <= s_task;
         entry_tile[free_id]     <= hash_dest;
         entry_tied[free_id]     <= s_tied;
         entry_cq_slot[free_id]  <= s_cq_slot;
         entry_child_id[free_id] <= s_child_id;
      end else if (reissue) begin
         enq_task             <= entry_task[retry_id];
         enq_tied             <= retry_tied;
         enq_dest             <= entry_tile[retry_id];
         enq_id               <= retry_id;
         entry_tied[retry_id] <= retry_tied;
      end
   end

   // tied responses only, held until the child manager takes them
   always_ff @(posedge clk) begin
      if (!rstn) begin
         m_resp_valid <= 1'b0;
      end else if (fwd_resp) begin
         m_resp_valid <= 1'b1;
      end else if (m_resp_ready) begin
         m_resp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fwd_resp) begin
         m_resp_ack      <= resp_ack;
         m_resp_id       <= resp_id;
         m_resp_epoch    <= resp_epoch;
         m_resp_slot     <= resp_slot;
         m_resp_tile     <= entry_tile[resp_id];
         m_resp_cq_slot  <= entry_cq_slot[resp_id];
         m_resp_child_id <= entry_child_id[resp_id];
      end
   end

   assign empty       = entry_valid == '0;
   assign almost_full = count > (TSB_SIZE - 4);

   // one entry per cycle, result published at the wrap
   always_ff @(posedge clk) begin
      if (!rstn) begin
         scan_id  <= '0;
         scan_min <= '1;
         lvt      <= '1;
      end else begin
         scan_id <= scan_id + 1'b1;
         if (scan_id == '0) begin
            lvt      <= scan_min;
            scan_min <= entry_valid[0] ? entry_task[0].ts : '1;
         end else if (entry_valid[scan_id] && (entry_task[scan_id].ts < scan_min)) begin
            scan_min <= entry_task[scan_id].ts;
         end
      end
   end

   assign wb_req = wb_cyc && wb_stb && !wb_ack;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wb_ack   <= 1'b0;
         n_tiles  <= 3'(N_TILES);
         use_hash <= 1'b0;
      end else begin
         wb_ack <= wb_req;
         if (wb_req && wb_we) begin
            case (wb_adr)
               TSB_REG_N_TILES: begin
                  n_tiles <= wb_dat_w[2:0];
               end
               TSB_REG_HASH: begin
                  use_hash <= wb_dat_w[0];
               end
               default: begin
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wb_req) begin
         case (wb_adr)
            TSB_REG_N_TILES: wb_dat_r <= {29'd0, n_tiles};
            TSB_REG_HASH:    wb_dat_r <= {31'd0, use_hash};
            TSB_REG_VALID:   wb_dat_r <= {{(32 - TSB_SIZE){1'b0}}, entry_valid};
            TSB_REG_COUNT:   wb_dat_r <= {{(31 - LOG_TSB_SIZE){1'b0}}, count};
         endcase
      end
   end

endmodule

/* tb_swarm_tsb_sys.sv */
`timescale 1ns/1ps

module tb_swarm_tsb_sys import swarm_cfg_pkg::*, swarm_types_pkg::*; ();

   // five tests need well under a thousand cycles
   localparam int MAX_CYCLES = 4000;

   logic                clk;
   logic                rstn;
   logic                s_valid;
   logic                s_ready;
   task_t               s_task;
   logic                s_tied;
   cq_slot_t            s_cq_slot;
   child_id_t           s_child_id;
   logic                retry_valid;
   logic                retry_ready;
   tsb_entry_id_t       retry_id;
   logic                retry_abort;
   logic                retry_tied;
   logic                m_resp_valid;
   logic                m_resp_ready;
   logic                m_resp_ack;
   tsb_entry_id_t       m_resp_id;
   epoch_t              m_resp_epoch;
   tq_slot_t            m_resp_slot;
   tile_id_t            m_resp_tile;
   cq_slot_t            m_resp_cq_slot;
   child_id_t           m_resp_child_id;
   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   logic [1:0]          wb_adr;
   logic [31:0]         wb_dat_w;
   logic [31:0]         wb_dat_r;
   logic                wb_ack;
   ts_t                 lvt;
   logic                empty;
   logic                almost_full;
   logic [N_TILES-1:0]  deq_valid;
   logic [N_TILES-1:0]  deq_ready;
   task_t [N_TILES-1:0] deq_task;

   // reference model state
   task_t               mq [N_TILES][$];
   tq_slot_t            m_wr [N_TILES];
   tq_slot_t            m_rd [N_TILES];
   epoch_t              m_ep [N_TILES][TQ_DEPTH];
   logic [TSB_SIZE-1:0] m_valid;
   task_t               m_task [TSB_SIZE];
   tile_id_t            m_tile [TSB_SIZE];
   cq_slot_t            m_cq [TSB_SIZE];
   child_id_t           m_child [TSB_SIZE];
   logic                use_hash_m;
   int                  n_tiles_m;
   logic                resp_expected;
   int                  cycles;
   int                  tile_counts [3] = '{4, 3, 1};

   swarm_tsb_sys i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stop_run();
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
      assert (act === exp) else begin
         $display("error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
         stop_run();
      end
   endtask

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         stop_run();
      end
   end

   a_enq_after_submit: assert property (@(posedge clk) disable iff (!rstn)
      s_valid && s_ready |=> i_dut.enq_valid)
      else begin
         $display("enq_valid did not rise one cycle after a submission handshake");
         stop_run();
      end

   a_enq_after_retry: assert property (@(posedge clk) disable iff (!rstn)
      retry_valid && retry_ready && !retry_abort |=> i_dut.enq_valid)
      else begin
         $display("enq_valid did not rise one cycle after a retry handshake");
         stop_run();
      end

   // untied tasks must stay silent toward the child manager
   a_resp_only_when_tied: assert property (@(posedge clk) disable iff (!rstn)
      m_resp_valid |-> resp_expected)
      else begin
         $display("child response appeared for a task that expects none");
         stop_run();
      end

   // dequeue order and per-slot epochs
   always @(posedge clk) begin
      if (rstn) begin
         for (int t = 0; t < N_TILES; t++) begin
            if (deq_valid[t] && deq_ready[t]) begin
               if (mq[t].size() == 0) begin
                  $display("tile %0d dequeued a task that was never routed to it", t);
                  stop_run();
               end
               expect_eq($sformatf("deq_task[%0d]", t), mq[t][0], deq_task[t]);
               void'(mq[t].pop_front());
               m_ep[t][m_rd[t]] = m_ep[t][m_rd[t]] + 1'b1;
               m_rd[t] = m_rd[t] + 1'b1;
            end
         end
      end
   end

   function automatic tile_id_t predict_tile(input locale_t loc, input logic hmode, input int n);
      logic [15:0] h;
      for (int i = 0; i < 16; i++) begin
         h[i] = hmode ? ^(loc[31:4] & hash_keys[i][31:4]) : loc[i + 4];
      end
      return tile_id_t'(h % n);
   endfunction

   function automatic tsb_entry_id_t lowest_free(input logic [TSB_SIZE-1:0] v);
      for (int i = 0; i < TSB_SIZE; i++) begin
         if (!v[i]) begin
            return tsb_entry_id_t'(i);
         end
      end
      return '0;
   endfunction

   function automatic task_t random_task();
      task_t t;
      t.ts      = 16'($urandom_range(16'hfffe));
      t.locale  = $urandom;
      t.payload = 16'($urandom);
      return t;
   endfunction

   task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_dat_w = data;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      @(negedge clk);
      while (!wb_ack) @(negedge clk);
      data   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic set_config(input logic hmode, input int n);
      logic [31:0] data;
      wb_write(TSB_REG_HASH, {31'd0, hmode});
      wb_write(TSB_REG_N_TILES, n);
      wb_read(TSB_REG_N_TILES, data);
      expect_eq("tile count register", n, data);
      wb_read(TSB_REG_HASH, data);
      expect_eq("hash mode register", {31'd0, hmode}, data);
      use_hash_m = hmode;
      n_tiles_m  = n;
   endtask

   task automatic check_occupancy();
      logic [31:0] data;
      int          n;
      n = $countones(m_valid);
      wb_read(TSB_REG_VALID, data);
      expect_eq("valid mask register", m_valid, data);
      wb_read(TSB_REG_COUNT, data);
      expect_eq("count register", n, data);
      expect_eq("almost_full", n > 4, almost_full);
      expect_eq("empty", n == 0, empty);
   endtask

   // tile model decides ack or nack, slot and epoch
   task automatic await_outcome(input tsb_entry_id_t id, input logic tied);
      tile_id_t tile;
      logic     ack;
      tq_slot_t slot;
      epoch_t   ep;
      tile = m_tile[id];
      ack  = mq[tile].size() < TQ_DEPTH;
      slot = m_wr[tile];
      ep   = m_ep[tile][slot];
      if (ack) begin
         mq[tile].push_back(m_task[id]);
         m_wr[tile] = m_wr[tile] + 1'b1;
      end
      if (tied) begin
         while (!m_resp_valid) @(negedge clk);
         expect_eq("m_resp_ack", ack, m_resp_ack);
         expect_eq("m_resp_id", id, m_resp_id);
         expect_eq("m_resp_tile", tile, m_resp_tile);
         expect_eq("m_resp_slot", slot, m_resp_slot);
         expect_eq("m_resp_epoch", ep, m_resp_epoch);
         expect_eq("m_resp_cq_slot", m_cq[id], m_resp_cq_slot);
         expect_eq("m_resp_child_id", m_child[id], m_resp_child_id);
         @(negedge clk);
         resp_expected = 1'b0;
      end else begin
         while (!empty) @(negedge clk);
      end
      if (ack) begin
         m_valid[id] = 1'b0;
      end
   endtask

   task automatic submit_task(input task_t t, input logic tied, output tsb_entry_id_t id);
      id            = lowest_free(m_valid);
      m_task[id]    = t;
      m_tile[id]    = predict_tile(t.locale, use_hash_m, n_tiles_m);
      m_cq[id]      = cq_slot_t'($urandom);
      m_child[id]   = child_id_t'($urandom);
      resp_expected = tied;
      s_valid       = 1'b1;
      s_task        = t;
      s_tied        = tied;
      s_cq_slot     = m_cq[id];
      s_child_id    = m_child[id];
      while (!s_ready) @(negedge clk);
      @(negedge clk);
      s_valid     = 1'b0;
      m_valid[id] = 1'b1;
      await_outcome(id, tied);
   endtask

   task automatic retry_entry(input tsb_entry_id_t id, input logic abort, input logic tied);
      resp_expected = tied && !abort;
      retry_valid   = 1'b1;
      retry_id      = id;
      retry_abort   = abort;
      retry_tied    = tied;
      while (!retry_ready) @(negedge clk);
      @(negedge clk);
      retry_valid = 1'b0;
      if (abort) begin
         m_valid[id] = 1'b0;
      end else begin
         await_outcome(id, tied);
      end
   endtask

   task automatic check_lvt(input ts_t exp);
      repeat (2 * TSB_SIZE) @(negedge clk);
      expect_eq("lvt", exp, lvt);
   endtask

   initial begin
      tsb_entry_id_t id;
      tsb_entry_id_t held [5];
      task_t         t;
      ts_t           min_ts;
      logic [31:0]   data;
      logic          leftover;
      void'($urandom(13));
      rstn          = 1'b0;
      s_valid       = 1'b0;
      s_task        = '0;
      s_tied        = 1'b0;
      s_cq_slot     = '0;
      s_child_id    = '0;
      retry_valid   = 1'b0;
      retry_id      = '0;
      retry_abort   = 1'b0;
      retry_tied    = 1'b0;
      m_resp_ready  = 1'b1;
      wb_cyc        = 1'b0;
      wb_stb        = 1'b0;
      wb_we         = 1'b0;
      wb_adr        = '0;
      wb_dat_w      = '0;
      deq_ready     = '1;
      m_valid       = '0;
      resp_expected = 1'b0;
      cycles        = 0;
      for (int i = 0; i < N_TILES; i++) begin
         m_wr[i] = '0;
         m_rd[i] = '0;
         for (int j = 0; j < TQ_DEPTH; j++) begin
            m_ep[i][j] = '0;
         end
      end
      repeat (3) @(negedge clk);
      rstn = 1'b1;
      expect_eq("enq_valid after reset", 0, i_dut.enq_valid);
      expect_eq("m_resp_valid after reset", 0, m_resp_valid);
      expect_eq("wb_ack after reset", 0, wb_ack);
      expect_eq("deq_valid after reset", 0, deq_valid);
      expect_eq("empty after reset", 1, empty);
      wb_read(TSB_REG_N_TILES, data);
      expect_eq("tile count register after reset", N_TILES, data);

      // routing in both modes, tied and untied alternating
      for (int m = 0; m < 2; m++) begin
         for (int c = 0; c < 3; c++) begin
            set_config(m[0], tile_counts[c]);
            for (int k = 0; k < 6; k++) begin
               submit_task(random_task(), k[0], id);
            end
         end
      end
      check_occupancy();

      // tile 2 stalled, four fit and the rest bounce
      set_config(1'b0, 4);
      deq_ready = 4'b1011;
      for (int k = 0; k < 4; k++) begin
         t = random_task();
         t.locale[5:4] = 2'd2;
         submit_task(t, 1'b1, id);
      end
      min_ts = '1;
      for (int k = 0; k < 5; k++) begin
         t = random_task();
         t.locale[5:4] = 2'd2;
         submit_task(t, 1'b1, held[k]);
         if (t.ts < min_ts) begin
            min_ts = t.ts;
         end
      end
      check_occupancy();
      check_lvt(min_ts);

      deq_ready = '1;
      while (mq[2].size() != 0) @(negedge clk);
      retry_entry(held[0], 1'b0, 1'b1);
      check_occupancy();
      retry_entry(held[1], 1'b1, 1'b0);
      check_occupancy();
      for (int k = 2; k < 5; k++) begin
         retry_entry(held[k], 1'b1, 1'b0);
      end
      check_occupancy();
      check_lvt(16'hffff);
      leftover = 1'b0;
      for (int i = 0; i < N_TILES; i++) begin
         if (mq[i].size() != 0) begin
            $display("tile %0d never dequeued %0d accepted tasks", i, mq[i].size());
            leftover = 1'b1;
         end
      end

      if (leftover) begin
         stop_run();
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

/* tile_hash.sv */
`timescale 1ns/1ps

module tile_hash import swarm_cfg_pkg::*, swarm_types_pkg::*; (
   input  locale_t    locale,
   input  logic       use_hash,
   input  logic [2:0] n_tiles,
   output tile_id_t   dest
);

   logic [15:0] hashed;
   logic [15:0] rem3;

   // low nibble of the locale never takes part
   for (genvar i = 0; i < 16; i++) begin : gen_bit
      assign hashed[i] = use_hash ? ^(locale[31:4] & hash_keys[i][31:4]) : locale[i + 4];
   end

   assign rem3 = hashed % 16'd3;

   always_comb begin
      case (n_tiles)
         3'd1: begin
            dest = 2'd0;
         end
         3'd2: begin
            dest = {1'b0, hashed[0]};
         end
         3'd3: begin
            dest = rem3[1:0];
         end
         default: begin
            dest = hashed[1:0];
         end
      endcase
   end

endmodule

/* tile_task_queue.sv */
`timescale 1ns/1ps

module tile_task_queue import swarm_cfg_pkg::*, swarm_types_pkg::*; (
   input  logic          clk,
   input  logic          rstn,
   input  logic          enq_valid,
   output logic          enq_ready,
   input  task_t         enq_task,
   input  tsb_entry_id_t enq_id,
   output logic          resp_valid,
   input  logic          resp_ready,
   output logic          resp_ack,
   output tsb_entry_id_t resp_id,
   output epoch_t        resp_epoch,
   output tq_slot_t      resp_slot,
   output logic          deq_valid,
   input  logic          deq_ready,
   output task_t         deq_task
);

   task_t      mem   [TQ_DEPTH];
   epoch_t     epoch [TQ_DEPTH];
   tq_slot_t   wr_ptr;
   tq_slot_t   rd_ptr;
   logic [2:0] used;
   logic       full;
   logic       enq_fire;
   logic       push;
   logic       pop;

   assign full      = used == TQ_DEPTH;
   // one response in flight per tile
   assign enq_ready = !resp_valid;
   assign enq_fire  = enq_valid && enq_ready;
   assign push      = enq_fire && !full;
   assign deq_valid = used != '0;
   assign deq_task  = mem[rd_ptr];
   assign pop       = deq_valid && deq_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         resp_valid <= 1'b0;
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         used       <= '0;
         for (int i = 0; i < TQ_DEPTH; i++) begin
            epoch[i] <= '0;
         end
      end else begin
         if (enq_fire) begin
            resp_valid <= 1'b1;
         end else if (resp_ready) begin
            resp_valid <= 1'b0;
         end
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr        <= rd_ptr + 1'b1;
            epoch[rd_ptr] <= epoch[rd_ptr] + 1'b1;
         end
         used <= used + {2'b00, push} - {2'b00, pop};
      end
   end

   // nack when no slot is free
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= enq_task;
      end
      if (enq_fire) begin
         resp_ack   <= !full;
         resp_id    <= enq_id;
         resp_slot  <= wr_ptr;
         resp_epoch <= epoch[wr_ptr];
      end
   end

endmodule
